// File: hw/qdma_st_macros.svh
// Stream width, queue, length, pattern, credit and counter size macros
`ifndef QDMA_ST_MACROS_SVH
`define QDMA_ST_MACROS_SVH

////////////////////
// Stream geometry
////////////////////
`define QDMA_DATA_W      256   // C2H and H2C beat width
`define QDMA_BEAT_BYTES  32    // Bytes per beat

////////////////////
// Field widths
////////////////////
`define QDMA_QID_W       11    // Queue ID
`define QDMA_LEN_W       16    // Packet length in bytes
`define QDMA_PATT_W      16    // One pattern lane

// Descriptor credits per request
`define QDMA_CRDT_W      16

// Perf counter and H2C status width
`define QDMA_CNTR_W      32

`endif

// File: hw/qdma_st_pkg.sv
// Stream data, queue, length, empty-byte, parity, credit and counter types; pattern function
`include "qdma_st_macros.svh"

package qdma_st_pkg;

    typedef logic [`QDMA_DATA_W-1:0]               data_t;   // One stream beat
    typedef logic [`QDMA_BEAT_BYTES-1:0]           dpar_t;   // Parity bit per byte
    typedef logic [`QDMA_QID_W-1:0]                qid_t;
    typedef logic [`QDMA_LEN_W-1:0]                len_t;
    typedef logic [$clog2(`QDMA_BEAT_BYTES):0]     mty_t;    // 0 to 31 empty bytes
    typedef logic [`QDMA_CRDT_W-1:0]               crdt_t;
    typedef logic [`QDMA_CNTR_W-1:0]               cntr_t;

    ////////////////////
    // Pattern rule
    ////////////////////

    // Lane k of beat b holds b * lanes + k, wrapped to the lane width
    function automatic data_t beat_pattern(input len_t beat);
        data_t       patt;
        int unsigned val;
        patt = '0;
        for (int k = 0; k < `QDMA_DATA_W / `QDMA_PATT_W; k++) begin
            val = beat * (`QDMA_DATA_W / `QDMA_PATT_W) + k;
            patt[k*`QDMA_PATT_W +: `QDMA_PATT_W] = val[`QDMA_PATT_W-1:0]; // Little-endian lanes
        end
        return patt;
    endfunction

endpackage

// File: hw/c2h_cmd_if.sv
// Packet command link from the C2H control to the beat generator, with modports
interface c2h_cmd_if;

    logic               cmd_valid;
    logic               cmd_ready;
    qdma_st_pkg::qid_t  cmd_qid;      // Queue of the packet
    qdma_st_pkg::len_t  cmd_len;      // Packet length in bytes
    logic               cmd_imm;      // Immediate data packet

    // Fields hold while cmd_valid is high and cmd_ready is low
    modport ctrl_mp (
        output cmd_valid,
        output cmd_qid,
        output cmd_len,
        output cmd_imm,
        input  cmd_ready
    );

    modport gen_mp (
        input  cmd_valid,
        input  cmd_qid,
        input  cmd_len,
        input  cmd_imm,
        output cmd_ready
    );

endinterface

// File: hw/c2h_pkt_ctrl.sv
// C2H request control: credit tracking, packet commands and descriptor decrements
module c2h_pkt_ctrl (
    input  logic                user_clk,
    input  logic                user_reset_n,

    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  qdma_st_pkg::qid_t   req_qid_i,
    input  qdma_st_pkg::len_t   req_len_i,
    input  qdma_st_pkg::crdt_t  req_credits_i,
    input  logic                imm_data_i,

    output logic                desc_dec_o,
    output qdma_st_pkg::qid_t   desc_dec_qid_o,

    c2h_cmd_if.ctrl_mp          cmd
);

    logic                req_ready_q;
    logic                cmd_valid_q;
    logic                desc_dec_q;
    qdma_st_pkg::crdt_t  crdt_q;       // Credits left for the current request
    qdma_st_pkg::qid_t   qid_q;
    qdma_st_pkg::len_t   len_q;
    logic                imm_q;
    logic                req_fire;
    logic                cmd_fire;

    assign req_fire = req_valid_i & req_ready_q;
    assign cmd_fire = cmd_valid_q & cmd.cmd_ready;

    ////////////////////
    // Credit FSM
    ////////////////////
    always_ff @(posedge user_clk) begin
        if (!user_reset_n) begin
            req_ready_q <= 1'b0;
            cmd_valid_q <= 1'b0;
            desc_dec_q  <= 1'b0;
            crdt_q      <= '0;
        end else begin
            desc_dec_q <= cmd_fire;                      // One pulse per command taken
            if (req_fire) begin
                crdt_q      <= req_credits_i;
                cmd_valid_q <= (req_credits_i != '0);
                req_ready_q <= (req_credits_i == '0);    // Zero credits, stay open
            end else if (cmd_fire) begin
                crdt_q      <= crdt_q - 1'b1;
                cmd_valid_q <= (crdt_q != 1);
                req_ready_q <= (crdt_q == 1);            // Last credit spent
            end else if (!cmd_valid_q) begin
                req_ready_q <= 1'b1;
            end
        end
    end

    // Request fields, held until every credit is spent
    always_ff @(posedge user_clk) begin
        if (req_fire) begin
            qid_q <= req_qid_i;
            len_q <= req_len_i;
            imm_q <= imm_data_i;
        end
    end

    assign req_ready_o    = req_ready_q;
    assign desc_dec_o     = desc_dec_q;
    assign desc_dec_qid_o = qid_q;   // Still the request's queue during the pulse

    assign cmd.cmd_valid = cmd_valid_q;
    assign cmd.cmd_qid   = qid_q;
    assign cmd.cmd_len   = len_q;
    assign cmd.cmd_imm   = imm_q;

endmodule

// File: hw/c2h_beat_gen.sv
// C2H beat generator: pattern data, last-beat empty bytes, byte parity and control fields
`include "qdma_st_macros.svh"

module c2h_beat_gen (
    input  logic                user_clk,
    input  logic                user_reset_n,

    c2h_cmd_if.gen_mp           cmd,

    output qdma_st_pkg::data_t  c2h_tdata_o,
    output qdma_st_pkg::dpar_t  c2h_dpar_o,
    output logic                c2h_tvalid_o,
    output logic                c2h_tlast_o,
    output qdma_st_pkg::mty_t   c2h_mty_o,
    output qdma_st_pkg::len_t   c2h_ctrl_len_o,
    output qdma_st_pkg::qid_t   c2h_ctrl_qid_o,
    output logic                c2h_ctrl_imm_data_o,
    input  logic                c2h_tready_i
);

    localparam int BEAT_SH = $clog2(`QDMA_BEAT_BYTES);

    logic                vld_q;
    qdma_st_pkg::len_t   beat_q;       // Beat index within the packet
    qdma_st_pkg::len_t   last_idx_q;   // Index of the final beat
    qdma_st_pkg::qid_t   qid_q;
    qdma_st_pkg::len_t   len_q;
    logic                imm_q;
    logic                is_last;
    logic                beat_fire;
    logic                cmd_fire;
    logic [BEAT_SH-1:0]  rem;          // Bytes used in a partial last beat

    assign is_last   = (beat_q == last_idx_q);
    assign beat_fire = vld_q & c2h_tready_i;

    // Accept the next command as the last beat leaves
    assign cmd.cmd_ready = ~vld_q | (is_last & c2h_tready_i);
    assign cmd_fire      = cmd.cmd_valid & cmd.cmd_ready;

    ////////////////////
    // Beat sequencing
    ////////////////////
    always_ff @(posedge user_clk) begin
        if (!user_reset_n) begin
            vld_q <= 1'b0;
        end else if (cmd_fire) begin
            vld_q <= 1'b1;
        end else if (beat_fire && is_last) begin
            vld_q <= 1'b0;
        end
    end

    always_ff @(posedge user_clk) begin
        if (cmd_fire) begin
            qid_q      <= cmd.cmd_qid;
            len_q      <= cmd.cmd_len;
            imm_q      <= cmd.cmd_imm;
            beat_q     <= '0;
            last_idx_q <= (cmd.cmd_len - 1'b1) >> BEAT_SH;   // ceil(len / 32) - 1
        end else if (beat_fire) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    ////////////////////
    // Beat contents
    ////////////////////
    assign c2h_tdata_o = qdma_st_pkg::beat_pattern(beat_q);

    // Odd parity per byte
    always_comb begin
        for (int j = 0; j < `QDMA_BEAT_BYTES; j++) begin
            c2h_dpar_o[j] = ~(^c2h_tdata_o[j*8 +: 8]);
        end
    end

    assign rem = len_q[BEAT_SH-1:0];

    always_comb begin
        if (is_last && rem != '0) begin
            c2h_mty_o = qdma_st_pkg::mty_t'(`QDMA_BEAT_BYTES - rem);
        end else begin
            c2h_mty_o = '0;                                  // Full beat
        end
    end

    assign c2h_tvalid_o        = vld_q;
    assign c2h_tlast_o         = is_last;
    assign c2h_ctrl_qid_o      = qid_q;
    assign c2h_ctrl_imm_data_o = imm_q;
    assign c2h_ctrl_len_o      = imm_q ? '0 : len_q;        // Immediate data carries no length

endmodule

// File: hw/h2c_pattern_chk.sv
// H2C receiver: per-byte pattern compare, per-packet error status and beat count
`include "qdma_st_macros.svh"

module h2c_pattern_chk (
    input  logic                user_clk,
    input  logic                user_reset_n,

    input  qdma_st_pkg::data_t  h2c_tdata_i,
    input  logic                h2c_tvalid_i,
    output logic                h2c_tready_o,
    input  logic                h2c_tlast_i,
    input  qdma_st_pkg::qid_t   h2c_tuser_qid_i,
    input  qdma_st_pkg::mty_t   h2c_tuser_mty_i,

    output logic                stat_vld_o,
    output qdma_st_pkg::cntr_t  stat_err_o,
    output qdma_st_pkg::qid_t   h2c_qid_o,
    output qdma_st_pkg::cntr_t  h2c_beat_cnt_o
);

    localparam int MIS_W = $clog2(`QDMA_BEAT_BYTES + 1);

    logic                tready_q;
    logic                beat_fire;
    qdma_st_pkg::len_t   beat_q;      // Beat index inside the packet
    qdma_st_pkg::data_t  exp_data;
    logic [MIS_W-1:0]    mis_cnt;     // Bad bytes in this beat
    qdma_st_pkg::cntr_t  err_acc;     // Bad bytes so far in this packet
    qdma_st_pkg::cntr_t  beat_total;  // Every accepted beat

    assign beat_fire = h2c_tvalid_i & tready_q;
    assign exp_data  = qdma_st_pkg::beat_pattern(beat_q);

    ////////////////////
    // Byte compare
    ////////////////////
    always_comb begin
        mis_cnt = '0;
        for (int j = 0; j < `QDMA_BEAT_BYTES; j++) begin
            // Top mty bytes of the last beat carry nothing
            if ((!h2c_tlast_i || j < (`QDMA_BEAT_BYTES - int'(h2c_tuser_mty_i))) &&
                h2c_tdata_i[j*8 +: 8] != exp_data[j*8 +: 8]) begin
                mis_cnt = mis_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge user_clk) begin
        if (!user_reset_n) begin
            tready_q       <= 1'b0;
            stat_vld_o     <= 1'b0;
            stat_err_o     <= '0;
            h2c_qid_o      <= '0;
            h2c_beat_cnt_o <= '0;
            beat_q         <= '0;
            err_acc        <= '0;
            beat_total     <= '0;
        end else begin
            tready_q   <= 1'b1;              // Never back-pressures
            stat_vld_o <= beat_fire & h2c_tlast_i;
            if (beat_fire) begin
                beat_total <= beat_total + 1'b1;
                if (h2c_tlast_i) begin
                    stat_err_o     <= err_acc + qdma_st_pkg::cntr_t'(mis_cnt);
                    h2c_qid_o      <= h2c_tuser_qid_i;
                    h2c_beat_cnt_o <= beat_total + 1'b1;
                    beat_q         <= '0;
                    err_acc        <= '0;
                end else begin
                    beat_q  <= beat_q + 1'b1;
                    err_acc <= err_acc + qdma_st_pkg::cntr_t'(mis_cnt);
                end
            end
        end
    end

    assign h2c_tready_o = tready_q;

endmodule

// File: hw/st_perf_cntr.sv
// Windowed free, idle, busy and active cycle counters for one valid/ready port
module st_perf_cntr (
    input  logic                user_clk,
    input  logic                user_reset_n,

    input  logic                valid_i,
    input  logic                ready_i,
    input  qdma_st_pkg::cntr_t  cntr_max_i,   // Window length in cycles
    input  logic                cntr_rst_i,   // Starts a new window

    output qdma_st_pkg::cntr_t  free_cnts_o,
    output qdma_st_pkg::cntr_t  idle_cnts_o,
    output qdma_st_pkg::cntr_t  busy_cnts_o,
    output qdma_st_pkg::cntr_t  actv_cnts_o
);

    logic counting;

    assign counting = (free_cnts_o != cntr_max_i);   // Window still open

    always_ff @(posedge user_clk) begin
        if (!user_reset_n || cntr_rst_i) begin
            free_cnts_o <= '0;
            idle_cnts_o <= '0;
            busy_cnts_o <= '0;
            actv_cnts_o <= '0;
        end else if (counting) begin
            free_cnts_o <= free_cnts_o + 1'b1;
            // Each cycle lands in exactly one class
            if (!valid_i) begin
                idle_cnts_o <= idle_cnts_o + 1'b1;
            end else if (!ready_i) begin
                busy_cnts_o <= busy_cnts_o + 1'b1;   // Stalled
            end else begin
                actv_cnts_o <= actv_cnts_o + 1'b1;
            end
        end
    end

endmodule

// File: hw/qdma_st_top.sv
// Streaming user logic top: C2H control and generator, H2C checker, C2H perf counter
module qdma_st_top (
    input  logic                user_clk,
    input  logic                user_reset_n,

    // Queue requests
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  qdma_st_pkg::qid_t   req_qid_i,
    input  qdma_st_pkg::len_t   req_len_i,
    input  qdma_st_pkg::crdt_t  req_credits_i,
    input  logic                imm_data_i,

    // C2H stream
    output qdma_st_pkg::data_t  c2h_tdata_o,
    output qdma_st_pkg::dpar_t  c2h_dpar_o,
    output logic                c2h_tvalid_o,
    input  logic                c2h_tready_i,
    output logic                c2h_tlast_o,
    output qdma_st_pkg::mty_t   c2h_mty_o,
    output qdma_st_pkg::len_t   c2h_ctrl_len_o,
    output qdma_st_pkg::qid_t   c2h_ctrl_qid_o,
    output logic                c2h_ctrl_imm_data_o,

    output logic                desc_dec_o,
    output qdma_st_pkg::qid_t   desc_dec_qid_o,

    // H2C stream and status
    input  qdma_st_pkg::data_t  h2c_tdata_i,
    input  logic                h2c_tvalid_i,
    output logic                h2c_tready_o,
    input  logic                h2c_tlast_i,
    input  qdma_st_pkg::qid_t   h2c_tuser_qid_i,
    input  qdma_st_pkg::mty_t   h2c_tuser_mty_i,
    output logic                stat_vld_o,
    output qdma_st_pkg::cntr_t  stat_err_o,
    output qdma_st_pkg::qid_t   h2c_qid_o,
    output qdma_st_pkg::cntr_t  h2c_beat_cnt_o,

    // C2H performance window
    input  qdma_st_pkg::cntr_t  cntr_max_i,
    input  logic                cntr_rst_i,
    output qdma_st_pkg::cntr_t  free_cnts_o,
    output qdma_st_pkg::cntr_t  idle_cnts_o,
    output qdma_st_pkg::cntr_t  busy_cnts_o,
    output qdma_st_pkg::cntr_t  actv_cnts_o
);

    c2h_cmd_if cmd_if ();

    c2h_pkt_ctrl u_pkt_ctrl (
        .user_clk       (user_clk),
        .user_reset_n   (user_reset_n),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .req_qid_i      (req_qid_i),
        .req_len_i      (req_len_i),
        .req_credits_i  (req_credits_i),
        .imm_data_i     (imm_data_i),
        .desc_dec_o     (desc_dec_o),
        .desc_dec_qid_o (desc_dec_qid_o),
        .cmd            (cmd_if.ctrl_mp)
    );

    c2h_beat_gen u_beat_gen (
        .user_clk            (user_clk),
        .user_reset_n        (user_reset_n),
        .cmd                 (cmd_if.gen_mp),
        .c2h_tdata_o         (c2h_tdata_o),
        .c2h_dpar_o          (c2h_dpar_o),
        .c2h_tvalid_o        (c2h_tvalid_o),
        .c2h_tlast_o         (c2h_tlast_o),
        .c2h_mty_o           (c2h_mty_o),
        .c2h_ctrl_len_o      (c2h_ctrl_len_o),
        .c2h_ctrl_qid_o      (c2h_ctrl_qid_o),
        .c2h_ctrl_imm_data_o (c2h_ctrl_imm_data_o),
        .c2h_tready_i        (c2h_tready_i)
    );

    h2c_pattern_chk u_pattern_chk (
        .user_clk        (user_clk),
        .user_reset_n    (user_reset_n),
        .h2c_tdata_i     (h2c_tdata_i),
        .h2c_tvalid_i    (h2c_tvalid_i),
        .h2c_tready_o    (h2c_tready_o),
        .h2c_tlast_i     (h2c_tlast_i),
        .h2c_tuser_qid_i (h2c_tuser_qid_i),
        .h2c_tuser_mty_i (h2c_tuser_mty_i),
        .stat_vld_o      (stat_vld_o),
        .stat_err_o      (stat_err_o),
        .h2c_qid_o       (h2c_qid_o),
        .h2c_beat_cnt_o  (h2c_beat_cnt_o)
    );

    // Watches the C2H handshake
    st_perf_cntr u_c2h_perf (
        .user_clk     (user_clk),
        .user_reset_n (user_reset_n),
        .valid_i      (c2h_tvalid_o),
        .ready_i      (c2h_tready_i),
        .cntr_max_i   (cntr_max_i),
        .cntr_rst_i   (cntr_rst_i),
        .free_cnts_o  (free_cnts_o),
        .idle_cnts_o  (idle_cnts_o),
        .busy_cnts_o  (busy_cnts_o),
        .actv_cnts_o  (actv_cnts_o)
    );

endmodule

// File: testbench/tb_qdma_st.sv
// Testbench for qdma_st_top with clock, reset, stimulus, scoreboards, assertions and report
`include "qdma_st_macros.svh"

module tb_qdma_st;

    localparam int NUM_REQ  = 10;
    localparam int NUM_H2C  = 9;
    localparam int WINDOW   = 150;     // Perf window in cycles
    localparam int WIN_HOLD = 8;       // Extra cycles the counters must hold
    localparam int BP_DEPTH = 1024;
    localparam int BYTES    = `QDMA_BEAT_BYTES;
    localparam int LANES    = `QDMA_DATA_W / `QDMA_PATT_W;

    typedef struct packed {
        qdma_st_pkg::qid_t qid;
        qdma_st_pkg::len_t len;
        logic              imm;
    } c2h_pkt_t;

    typedef struct packed {
        qdma_st_pkg::cntr_t err;
        qdma_st_pkg::qid_t  qid;
        qdma_st_pkg::cntr_t beats;
    } h2c_stat_t;

    logic user_clk     = 1'b0;
    logic user_reset_n = 1'b0;
    logic req_valid_i, req_ready_o, imm_data_i;
    qdma_st_pkg::qid_t   req_qid_i, c2h_ctrl_qid_o, desc_dec_qid_o, h2c_tuser_qid_i, h2c_qid_o;
    qdma_st_pkg::len_t   req_len_i, c2h_ctrl_len_o;
    qdma_st_pkg::crdt_t  req_credits_i;
    qdma_st_pkg::data_t  c2h_tdata_o, h2c_tdata_i;
    qdma_st_pkg::dpar_t  c2h_dpar_o;
    qdma_st_pkg::mty_t   c2h_mty_o, h2c_tuser_mty_i;
    logic c2h_tvalid_o, c2h_tlast_o, c2h_ctrl_imm_data_o, desc_dec_o;
    logic c2h_tready_i = 1'b0;
    logic h2c_tvalid_i, h2c_tlast_i, h2c_tready_o, stat_vld_o, cntr_rst_i;
    qdma_st_pkg::cntr_t  stat_err_o, h2c_beat_cnt_o, cntr_max_i;
    qdma_st_pkg::cntr_t  free_cnts_o, idle_cnts_o, busy_cnts_o, actv_cnts_o;

    // Scoreboards and run state
    c2h_pkt_t          c2h_exp_q[$];
    qdma_st_pkg::qid_t dec_qid_q[$];
    h2c_stat_t         h2c_exp_q[$];
    c2h_pkt_t          cur_pkt, new_pkt;
    logic              bp [BP_DEPTH];
    int mismatch_cnt = 0;
    int failure_cnt  = 0;
    int cycle_cnt    = 0;
    int timeout_limit = 100000;
    int c2h_beat = 0;
    int h2c_total = 0;
    int exp_beats, exp_mty, k;
    logic exp_last;
    qdma_st_pkg::dpar_t exp_par;
    logic stall_q = 1'b0;
    qdma_st_pkg::data_t held_data;
    logic [34:0] held_ctl;
    int win_cnt, win_actv, win_busy;
    logic win_open  = 1'b0;
    logic perf_done = 1'b0;

    qdma_st_top uut (.*);

    always #4 user_clk = ~user_clk;

    // Back-pressure pattern replayed on the falling edge
    always @(negedge user_clk) begin
        c2h_tready_i = user_reset_n ? bp[cycle_cnt % BP_DEPTH] : 1'b0;
    end

    //////////////////////
    // Helpers
    //////////////////////
    task automatic show_mismatch(input string name, input logic [255:0] exp_v,
                                 input logic [255:0] act_v);
        $display("MISMATCH t=%0t %s expected %0h got %0h", $time, name, exp_v, act_v);
        mismatch_cnt++;
    endtask

    task automatic note_failure(input string what);
        $display("ERROR t=%0t %s", $time, what);
        failure_cnt++;
    endtask

    // Byte j of beat b is byte j%2 of lane b*lanes + j/2
    function automatic qdma_st_pkg::data_t expected_beat(input int beat);
        qdma_st_pkg::data_t d;
        logic [15:0] lane;
        for (int j = 0; j < BYTES; j++) begin
            lane = 16'(beat * LANES + j / 2);
            d[j*8 +: 8] = (j % 2 == 1) ? lane[15:8] : lane[7:0];
        end
        return d;
    endfunction

    task automatic send_request(input int qid, input int len, input int crd, input logic imm);
        req_valid_i   = 1'b1;
        req_qid_i     = qdma_st_pkg::qid_t'(qid);
        req_len_i     = qdma_st_pkg::len_t'(len);
        req_credits_i = qdma_st_pkg::crdt_t'(crd);
        imm_data_i    = imm;
        while (!req_ready_o) @(negedge user_clk);
        @(negedge user_clk);
        req_valid_i = 1'b0;
    endtask

    // Corrupts nbad valid bytes, or every empty byte when bad_empty is set
    task automatic send_h2c(input int qid, input int len, input int nbad, input logic bad_empty);
        int nbeats;
        int step;
        int pos;
        h2c_stat_t e;
        qdma_st_pkg::data_t d;
        nbeats = (len + BYTES - 1) / BYTES;
        step = (nbad > 0) ? len / nbad : 1;
        h2c_total += nbeats;
        e.err   = qdma_st_pkg::cntr_t'(nbad);
        e.qid   = qdma_st_pkg::qid_t'(qid);
        e.beats = qdma_st_pkg::cntr_t'(h2c_total);
        h2c_exp_q.push_back(e);
        for (int b = 0; b < nbeats; b++) begin
            d = expected_beat(b);
            for (int j = 0; j < BYTES; j++) begin
                pos = b * BYTES + j;
                if ((pos < len && nbad > 0 && pos % step == 0 && pos / step < nbad) ||
                    (bad_empty && pos >= len)) begin
                    d[j*8 +: 8] = d[j*8 +: 8] ^ 8'h5a;
                end
            end
            h2c_tvalid_i    = 1'b1;
            h2c_tdata_i     = d;
            h2c_tlast_i     = (b == nbeats - 1);
            h2c_tuser_qid_i = qdma_st_pkg::qid_t'(qid);
            h2c_tuser_mty_i = h2c_tlast_i ?
                              qdma_st_pkg::mty_t'((BYTES - len % BYTES) % BYTES) : '0;
            while (!h2c_tready_o) @(negedge user_clk);
            @(negedge user_clk);
        end
        h2c_tvalid_i = 1'b0;
        h2c_tlast_i  = 1'b0;
    endtask

    //////////////////////
    // Checkers
    //////////////////////
    assert property (@(posedge user_clk) disable iff (!user_reset_n)
        c2h_tvalid_o && !c2h_tready_i |=> c2h_tvalid_o)
        else note_failure("c2h_tvalid_o dropped while a beat was stalled");

    // H2C side never back-pressures once out of reset
    assert property (@(posedge user_clk) disable iff (!user_reset_n)
        $past(user_reset_n) |-> h2c_tready_o)
        else show_mismatch("h2c_tready_o", 1'b1, h2c_tready_o);

    always @(posedge user_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > timeout_limit) begin
            $display("ERROR: run stopped after %0d cycles, traffic did not complete", cycle_cnt);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    always @(posedge user_clk) begin
        if (user_reset_n) begin
            // Request port and descriptor decrements
            assert (!req_ready_o || dec_qid_q.size() == (desc_dec_o ? 1 : 0))
                else note_failure("req_ready_o high while commands were still pending");
            if (desc_dec_o) begin
                assert (dec_qid_q.size() != 0) else note_failure("desc_dec_o with no credit left");
                if (dec_qid_q.size() != 0) begin
                    assert (desc_dec_qid_o == dec_qid_q[0])
                        else show_mismatch("desc_dec_qid_o", dec_qid_q[0], desc_dec_qid_o);
                    void'(dec_qid_q.pop_front());
                end
            end
            if (req_valid_i && req_ready_o) begin
                new_pkt.qid = req_qid_i;
                new_pkt.len = req_len_i;
                new_pkt.imm = imm_data_i;
                for (k = 0; k < int'(req_credits_i); k++) begin
                    c2h_exp_q.push_back(new_pkt);
                    dec_qid_q.push_back(req_qid_i);
                end
            end

            // Held beat must not change under back-pressure
            if (stall_q) begin
                assert (c2h_tdata_o == held_data)
                    else show_mismatch("c2h_tdata_o (stalled)", held_data, c2h_tdata_o);
                assert ({c2h_tlast_o, c2h_mty_o, c2h_ctrl_len_o, c2h_ctrl_qid_o,
                         c2h_ctrl_imm_data_o} == held_ctl)
                    else show_mismatch("C2H control fields (stalled)", held_ctl,
                                       {c2h_tlast_o, c2h_mty_o, c2h_ctrl_len_o,
                                        c2h_ctrl_qid_o, c2h_ctrl_imm_data_o});
            end
            stall_q   <= c2h_tvalid_o && !c2h_tready_i;
            held_data <= c2h_tdata_o;
            held_ctl  <= {c2h_tlast_o, c2h_mty_o, c2h_ctrl_len_o, c2h_ctrl_qid_o,
                          c2h_ctrl_imm_data_o};

            if (c2h_tvalid_o) begin
                for (k = 0; k < BYTES; k++) begin
                    exp_par[k] = ~^c2h_tdata_o[k*8 +: 8];
                end
                assert (c2h_dpar_o == exp_par)
                    else show_mismatch("c2h_dpar_o", exp_par, c2h_dpar_o);
            end

            // Accepted C2H beat against the scoreboard
            if (c2h_tvalid_o && c2h_tready_i) begin
                assert (c2h_exp_q.size() != 0)
                    else note_failure("C2H beat with no packet expected");
                if (c2h_exp_q.size() != 0) begin
                    cur_pkt   = c2h_exp_q[0];
                    exp_beats = (int'(cur_pkt.len) + BYTES - 1) / BYTES;
                    exp_last  = (c2h_beat == exp_beats - 1);
                    exp_mty   = (exp_last && cur_pkt.len % BYTES != 0) ?
                                BYTES - cur_pkt.len % BYTES : 0;
                    assert (c2h_tdata_o == expected_beat(c2h_beat))
                        else show_mismatch("c2h_tdata_o", expected_beat(c2h_beat), c2h_tdata_o);
                    assert (c2h_tlast_o == exp_last)
                        else show_mismatch("c2h_tlast_o", exp_last, c2h_tlast_o);
                    assert (c2h_mty_o == qdma_st_pkg::mty_t'(exp_mty))
                        else show_mismatch("c2h_mty_o", exp_mty, c2h_mty_o);
                    assert (c2h_ctrl_qid_o == cur_pkt.qid)
                        else show_mismatch("c2h_ctrl_qid_o", cur_pkt.qid, c2h_ctrl_qid_o);
                    assert (c2h_ctrl_imm_data_o == cur_pkt.imm)
                        else show_mismatch("c2h_ctrl_imm_data_o", cur_pkt.imm, c2h_ctrl_imm_data_o);
                    assert (c2h_ctrl_len_o == (cur_pkt.imm ? '0 : cur_pkt.len))
                        else show_mismatch("c2h_ctrl_len_o", cur_pkt.imm ? '0 : cur_pkt.len,
                                           c2h_ctrl_len_o);
                    if (exp_last) begin
                        void'(c2h_exp_q.pop_front());
                        c2h_beat = 0;
                    end else begin
                        c2h_beat++;
                    end
                end
            end

            // H2C per-packet status
            if (stat_vld_o) begin
                assert (h2c_exp_q.size() != 0)
                    else note_failure("stat_vld_o with no H2C packet sent");
                if (h2c_exp_q.size() != 0) begin
                    assert (stat_err_o == h2c_exp_q[0].err)
                        else show_mismatch("stat_err_o", h2c_exp_q[0].err, stat_err_o);
                    assert (h2c_qid_o == h2c_exp_q[0].qid)
                        else show_mismatch("h2c_qid_o", h2c_exp_q[0].qid, h2c_qid_o);
                    assert (h2c_beat_cnt_o == h2c_exp_q[0].beats)
                        else show_mismatch("h2c_beat_cnt_o", h2c_exp_q[0].beats, h2c_beat_cnt_o);
                    void'(h2c_exp_q.pop_front());
                end
            end

            // Perf window compared a few cycles after the counters stop
            if (cntr_rst_i) begin
                win_open = 1'b1;
                win_cnt  = 0;
                win_actv = 0;
                win_busy = 0;
            end else if (win_open && win_cnt == WINDOW + WIN_HOLD) begin
                assert (free_cnts_o == WINDOW)
                    else show_mismatch("free_cnts_o", WINDOW, free_cnts_o);
                assert (free_cnts_o == idle_cnts_o + busy_cnts_o + actv_cnts_o)
                    else show_mismatch("free_cnts_o (class sum)",
                                       idle_cnts_o + busy_cnts_o + actv_cnts_o, free_cnts_o);
                assert (actv_cnts_o == win_actv)
                    else show_mismatch("actv_cnts_o", win_actv, actv_cnts_o);
                assert (busy_cnts_o == win_busy)
                    else show_mismatch("busy_cnts_o", win_busy, busy_cnts_o);
                win_open  = 1'b0;
                perf_done = 1'b1;
            end else if (win_open) begin
                if (win_cnt < WINDOW) begin
                    if (c2h_tvalid_o && c2h_tready_i) win_actv++;
                    else if (c2h_tvalid_o) win_busy++;
                end
                win_cnt++;
            end
        end
    end

    //////////////////////
    // Stimulus
    //////////////////////
    initial begin
        int r_len [NUM_REQ];
        int r_crd [NUM_REQ];
        int r_qid [NUM_REQ];
        logic r_imm [NUM_REQ];
        int h_len [NUM_H2C];
        int h_qid [NUM_H2C];
        int h_bad [NUM_H2C];
        int limit_sum;
        void'($urandom(32'haa6beadd));
        req_valid_i = 1'b0;
        req_qid_i = '0;
        req_len_i = '0;
        req_credits_i = '0;
        imm_data_i = 1'b0;
        h2c_tdata_i = '0;
        h2c_tvalid_i = 1'b0;
        h2c_tlast_i = 1'b0;
        h2c_tuser_qid_i = '0;
        h2c_tuser_mty_i = '0;
        cntr_max_i = '0;
        cntr_rst_i = 1'b0;
        for (int i = 0; i < BP_DEPTH; i++) bp[i] = ($urandom % 4) != 0;
        for (int i = 0; i < NUM_REQ; i++) begin
            r_len[i] = 1 + $urandom % 200;
            r_crd[i] = $urandom % 5;
            r_qid[i] = $urandom % 2048;
            r_imm[i] = ($urandom % 4) == 0;
        end
        r_crd[1] = 0;                 // Request that sends nothing
        r_imm[2] = 1'b1;
        if (r_crd[2] == 0) r_crd[2] = 1;   // Immediate request sends at least one packet
        for (int i = 0; i < NUM_H2C; i++) begin
            h_len[i] = (i == 2) ? 45 : 1 + $urandom % 200;
            h_qid[i] = $urandom % 2048;
            h_bad[i] = (i % 3 == 1) ? 1 + $urandom % 5 : 0;
            if (h_bad[i] > h_len[i]) h_bad[i] = h_len[i];
        end
        limit_sum = WINDOW + 20 * (NUM_REQ + NUM_H2C);
        for (int i = 0; i < NUM_REQ; i++) limit_sum += r_crd[i] * ((r_len[i] + BYTES - 1) / BYTES);
        for (int i = 0; i < NUM_H2C; i++) limit_sum += (h_len[i] + BYTES - 1) / BYTES;
        timeout_limit = 2 * limit_sum;

        repeat (5) @(negedge user_clk);
        user_reset_n = 1'b1;
        @(negedge user_clk);
        cntr_max_i = qdma_st_pkg::cntr_t'(WINDOW);   // Window covers the C2H traffic
        cntr_rst_i = 1'b1;
        @(negedge user_clk);
        cntr_rst_i = 1'b0;

        for (int i = 0; i < NUM_REQ; i++) begin
            send_request(r_qid[i], r_len[i], r_crd[i], r_imm[i]);
            repeat ($urandom % 3) @(negedge user_clk);
        end
        // Every third H2C packet is dirty in its empty bytes only
        for (int i = 0; i < NUM_H2C; i++) begin
            send_h2c(h_qid[i], h_len[i], h_bad[i], i % 3 == 2);
        end

        while (c2h_exp_q.size() != 0 || dec_qid_q.size() != 0 || h2c_exp_q.size() != 0 ||
               !perf_done) begin
            @(negedge user_clk);
        end
        repeat (4) @(negedge user_clk);
        $display("Error counts: %0d mismatches, %0d other failures", mismatch_cnt, failure_cnt);
        if (mismatch_cnt == 0 && failure_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+hw
hw/qdma_st_pkg.sv
hw/c2h_cmd_if.sv
hw/c2h_pkt_ctrl.sv
hw/c2h_beat_gen.sv
hw/h2c_pattern_chk.sv
hw/st_perf_cntr.sv
hw/qdma_st_top.sv
testbench/tb_qdma_st.sv

// File: Makefile
# Verilator build and run for the QDMA streaming user logic

VERILATOR ?= verilator
TOP       ?= tb_qdma_st
RTL_TOP   ?= qdma_st_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# The log decides the result, not the simulator exit status
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
